// ==== hw/sha256_pkg.sv ====
/*
 * Shared SHA-256 definitions for the header-tail hashing pipeline.
 * Holds word and window types, round constants, padding words and the bit functions
 * used by the RTL stages and by the testbench reference model.
 */

package sha256_pkg;

	// Pipeline sizes
	localparam int NUM_ROUNDS  = 64;
	localparam int TAIL_WORDS  = 4;
	localparam int SCHED_WORDS = 16;
	localparam int CNT_W       = $clog2(NUM_ROUNDS + 1);

	// One SHA-256 word
	typedef logic [31:0] word_t;

	// Working variables, a at index 7 down to h at index 0
	typedef word_t [7:0] state_t;

	// Message-schedule window, oldest word at index 0
	typedef word_t [SCHED_WORDS-1:0] sched_t;

	// Header tail, element i is block word i
	typedef word_t [TAIL_WORDS-1:0] tail_t;

	// Fixed words of the second block of an 80-byte header
	localparam word_t PAD_WORD = 32'h8000_0000;
	localparam word_t LEN_WORD = 32'h0000_0280;

	localparam word_t ROUND_K [NUM_ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Rotate right by a constant amount
	function automatic word_t rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t big_sigma0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	// Schedule functions mix a rotate pair with a plain shift
	function automatic word_t small_sigma0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	// e picks between f and g bit by bit
	function automatic word_t ch(input word_t e, input word_t f, input word_t g);
		return (e & f) ^ (~e & g);
	endfunction

	// Bitwise majority of three words
	function automatic word_t maj(input word_t a, input word_t b, input word_t c);
		return (a & b) ^ (a & c) ^ (b & c);
	endfunction

endpackage

// ==== hw/sha256_sched_stage.sv ====
/*
 * One message-schedule step of the unrolled pipeline.
 * Shifts the 16-word window down by one and appends the next schedule word.
 */

`timescale 1ns/1ps

module sha256_sched_stage
	import sha256_pkg::*;
(
	input  logic   CLK,
	input  logic   RST,
	input  logic   en_i,
	input  sched_t window_i,
	output sched_t window_o
);

	word_t w_next;

	// W[t+16] from W[t], W[t+1], W[t+9] and W[t+14]
	assign w_next = small_sigma1(window_i[14]) + window_i[9]
		+ small_sigma0(window_i[1]) + window_i[0];

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			window_o <= '0;
		end else if (en_i) begin
			window_o <= {w_next, window_i[SCHED_WORDS-1:1]};
		end
	end

	// An X here would spread through every later stage of the chain
	a_window_known: assert property (
		@(posedge CLK) disable iff (!RST)
		!$isunknown(window_o)
	) else $error("schedule window holds unknown bits");

endmodule

// ==== hw/sha256_round_stage.sv ====
/*
 * One registered SHA-256 compression round.
 * ROUND selects the round constant; the schedule word arrives on w_i
 * in the same cycle as the working state it belongs to.
 */

`timescale 1ns/1ps

module sha256_round_stage
	import sha256_pkg::*;
#(
	parameter int ROUND = 0
) (
	input  logic   CLK,
	input  logic   RST,
	input  logic   en_i,
	input  word_t  w_i,
	input  state_t state_i,
	output state_t state_o
);

	word_t a;
	word_t b;
	word_t c;
	word_t d;
	word_t e;
	word_t f;
	word_t g;
	word_t h;
	word_t t1;
	word_t t2;

	assign {a, b, c, d, e, f, g, h} = state_i;

	assign t1 = h + big_sigma1(e) + ch(e, f, g) + ROUND_K[ROUND] + w_i;
	assign t2 = big_sigma0(a) + maj(a, b, c);

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state_o <= '0;
		end else if (en_i) begin
			// New a and e take the sums, the rest shift along
			state_o <= {t1 + t2, a, b, c, d + t1, e, f, g};
		end
	end

	a_round_index: assert property (
		@(posedge CLK) (ROUND >= 0) && (ROUND < NUM_ROUNDS)
	) else $error("round index %0d out of range", ROUND);

endmodule

// ==== hw/sha256_digest_out.sv ====
/*
 * Output register of the tail pipeline.
 * Counts enabled edges until the pipeline is full, then adds the midstate
 * to the last round state and raises valid for good.
 */

`timescale 1ns/1ps

module sha256_digest_out
	import sha256_pkg::*;
(
	input  logic   CLK,
	input  logic   RST,
	input  logic   en_i,
	input  state_t midstate_i,
	input  state_t state_i,
	output state_t digest_o,
	output logic   valid_o
);

	logic [CNT_W-1:0] cnt_q;
	logic             full;

	// State 64 holds a real item once 64 enabled edges have passed
	assign full = (cnt_q == CNT_W'(NUM_ROUNDS));

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			cnt_q    <= '0;
			valid_o  <= 1'b0;
			digest_o <= '0;
		end else if (en_i) begin
			if (full) begin
				valid_o <= 1'b1;
				for (int i = 0; i < 8; i++) begin
					digest_o[i] <= midstate_i[i] + state_i[i];
				end
			end else begin
				cnt_q    <= cnt_q + 1'b1;
				valid_o  <= 1'b0;
				digest_o <= '0;
			end
		end
	end

	// Once full the pipeline stays full until the next reset
	a_valid_sticky: assert property (
		@(posedge CLK) disable iff (!RST)
		valid_o |=> valid_o
	) else $error("valid_o fell while out of reset");

	// en_i low is the only back-pressure and must freeze the output
	a_digest_hold: assert property (
		@(posedge CLK) disable iff (!RST)
		!en_i |=> $stable(digest_o) && $stable(valid_o)
	) else $error("output changed while en_i was low");

endmodule

// ==== hw/sha256_tail_pipeline.sv ====
/*
 * Fully unrolled SHA-256 pipeline for the second block of an 80-byte header.
 * Takes a fixed midstate and one 128-bit tail per enabled cycle; the digest of
 * each tail appears 65 enabled edges later with valid_o high.
 */

`timescale 1ns/1ps

module sha256_tail_pipeline
	import sha256_pkg::*;
(
	input  logic   CLK,
	input  logic   RST,
	input  logic   en_i,
	input  state_t midstate_i,
	input  tail_t  tail_i,
	output state_t digest_o,
	output logic   valid_o
);

	// Entry r feeds stage r, entry r+1 is its registered result
	sched_t window [NUM_ROUNDS+1];
	state_t state  [NUM_ROUNDS+1];

	// Padded block: tail words, pad word, ten zero words, length word
	assign window[0] = {
		LEN_WORD,
		{(SCHED_WORDS - TAIL_WORDS - 2){32'h0}},
		PAD_WORD,
		tail_i
	};

	// Round 0 starts from the midstate of the first block
	assign state[0] = midstate_i;

	for (genvar r = 0; r < NUM_ROUNDS; r++) begin : g_stage
		sha256_sched_stage u_sched (
			.CLK      (CLK),
			.RST      (RST),
			.en_i     (en_i),
			.window_i (window[r]),
			.window_o (window[r+1])
		);

		// Oldest window word is W[r] for this stage
		sha256_round_stage #(
			.ROUND (r)
		) u_round (
			.CLK     (CLK),
			.RST     (RST),
			.en_i    (en_i),
			.w_i     (window[r][0]),
			.state_i (state[r]),
			.state_o (state[r+1])
		);
	end

	sha256_digest_out u_digest_out (
		.CLK        (CLK),
		.RST        (RST),
		.en_i       (en_i),
		.midstate_i (midstate_i),
		.state_i    (state[NUM_ROUNDS]),
		.digest_o   (digest_o),
		.valid_o    (valid_o)
	);

endmodule

// ==== tb/tb_clock.sv ====
/*
 * Clock and reset source for the testbench.
 * Drives CLK with a 100 ns period and holds RST low for the first cycles.
 */

`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 3
) (
	output logic CLK,
	output logic RST
);

	initial begin
		CLK = 1'b0;
		forever #(HALF_PERIOD) CLK = ~CLK;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		RST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b1;
	end

endmodule

// ==== tb/sha256_ref.svh ====
/*
 * Reference model for the tail pipeline testbench.
 * Builds the padded second block from a tail and runs a plain 64-round compression,
 * then adds the midstate. Included inside the testbench module.
 */

`ifndef SHA256_REF_SVH
`define SHA256_REF_SVH

function automatic state_t sha256_ref(input state_t mid, input tail_t tail);
	word_t  w [64];
	word_t  va;
	word_t  vb;
	word_t  vc;
	word_t  vd;
	word_t  ve;
	word_t  vf;
	word_t  vg;
	word_t  vh;
	word_t  t1;
	word_t  t2;
	state_t result;

	// Block words 0 to 3 come from the tail, then padding and the bit length
	for (int t = 0; t < 16; t++) begin
		w[t] = 32'h0;
	end
	for (int t = 0; t < 4; t++) begin
		w[t] = tail[t];
	end
	w[4]  = 32'h8000_0000;
	w[15] = 32'h0000_0280;

	// Full message schedule
	for (int t = 16; t < 64; t++) begin
		w[t] = small_sigma1(w[t-2]) + w[t-7] + small_sigma0(w[t-15]) + w[t-16];
	end

	// Word 7 of the state is a
	va = mid[7];
	vb = mid[6];
	vc = mid[5];
	vd = mid[4];
	ve = mid[3];
	vf = mid[2];
	vg = mid[1];
	vh = mid[0];

	for (int t = 0; t < 64; t++) begin
		t1 = vh + big_sigma1(ve) + ch(ve, vf, vg) + ROUND_K[t] + w[t];
		t2 = big_sigma0(va) + maj(va, vb, vc);
		vh = vg;
		vg = vf;
		vf = ve;
		ve = vd + t1;
		vd = vc;
		vc = vb;
		vb = va;
		va = t1 + t2;
	end

	result[7] = mid[7] + va;
	result[6] = mid[6] + vb;
	result[5] = mid[5] + vc;
	result[4] = mid[4] + vd;
	result[3] = mid[3] + ve;
	result[2] = mid[2] + vf;
	result[1] = mid[1] + vg;
	result[0] = mid[0] + vh;
	return result;
endfunction

`endif

// ==== tb/tb_sha256_tail_pipeline.sv ====
/*
 * Testbench for the SHA-256 header-tail pipeline.
 * Streams random tails with and without stalls, switches the midstate once,
 * and compares every valid digest with the reference model.
 */

`timescale 1ns/1ps

module tb_sha256_tail_pipeline
	import sha256_pkg::*;
();

	localparam int SEED         = 32'h3d11303a;
	localparam int LATENCY      = NUM_ROUNDS + 1;
	localparam int STREAM_ITEMS = 200;
	localparam int STALL_ITEMS  = 150;
	localparam int NEW_ITEMS    = LATENCY + 100;
	localparam int MAX_CYCLES   = 2000;

	// SHA-256 initial hash values, a first
	localparam state_t IV = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	logic   CLK;
	logic   RST;
	logic   en_i;
	state_t midstate_i;
	tail_t  tail_i;
	state_t digest_o;
	logic   valid_o;

	// One entry per enabled edge, oldest first
	tail_t  tail_q [$];
	state_t mid_q [$];

	int errors   = 0;
	int checked  = 0;
	int skipped  = 0;
	int en_count = 0;
	int cycles   = 0;

	logic   prev_en     = 1'b0;
	logic   prev_valid  = 1'b0;
	state_t prev_digest = '0;

	`include "sha256_ref.svh"

	tb_clock u_clock (
		.CLK (CLK),
		.RST (RST)
	);

	sha256_tail_pipeline dut (
		.CLK        (CLK),
		.RST        (RST),
		.en_i       (en_i),
		.midstate_i (midstate_i),
		.tail_i     (tail_i),
		.digest_o   (digest_o),
		.valid_o    (valid_o)
	);

	function automatic tail_t random_tail();
		tail_t t;
		for (int i = 0; i < TAIL_WORDS; i++) begin
			t[i] = $urandom;
		end
		return t;
	endfunction

	function automatic state_t random_state();
		state_t s;
		for (int i = 0; i < 8; i++) begin
			s[i] = $urandom;
		end
		return s;
	endfunction

	// Inputs change only on the falling edge
	task automatic drive(input logic en, input tail_t tail, input state_t mid);
		@(negedge CLK);
		en_i       = en;
		tail_i     = tail;
		midstate_i = mid;
	endtask

	initial begin : stimulus
		int     gap;
		state_t new_mid;

		void'($urandom(SEED));
		en_i       = 1'b0;
		tail_i     = '0;
		midstate_i = IV;
		@(posedge RST);

		// The first tail is the single item, the rest follow back to back
		for (int i = 0; i < STREAM_ITEMS; i++) begin
			drive(1'b1, random_tail(), IV);
		end

		// Random stalls, tail keeps changing while en_i is low
		for (int i = 0; i < STALL_ITEMS; i++) begin
			if ($urandom_range(3, 0) == 0) begin
				gap = $urandom_range(3, 1);
				repeat (gap) drive(1'b0, random_tail(), IV);
			end
			drive(1'b1, random_tail(), IV);
		end

		new_mid = random_state();
		for (int i = 0; i < NEW_ITEMS; i++) begin
			drive(1'b1, random_tail(), new_mid);
		end

		// Flush the last real items out of the pipeline
		repeat (LATENCY) drive(1'b1, random_tail(), new_mid);
		@(posedge CLK);
		#1;

		if (skipped != LATENCY) begin
			errors++;
			$display("Skipped %0d outputs around the midstate change, expected %0d",
				skipped, LATENCY);
		end
		if (checked != en_count - 2 * LATENCY) begin
			errors++;
			$display("Compared %0d digests, expected %0d", checked, en_count - 2 * LATENCY);
		end

		$display("Errors: %0d, digests checked: %0d, skipped: %0d, enabled cycles: %0d",
			errors, checked, skipped, en_count);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Samples on the rising edge, before the DUT registers update
	always @(posedge CLK) begin : compare
		tail_t  exp_tail;
		state_t exp_mid;
		state_t expected;

		if (RST) begin
			if (!prev_en && (digest_o !== prev_digest || valid_o !== prev_valid)) begin
				errors++;
				$display("[ERROR] %0t: output changed across a stalled cycle", $time);
			end
			if (en_i) begin
				if (valid_o !== (en_count >= LATENCY)) begin
					errors++;
					$display("[ERROR] %0t: valid_o is %b after %0d enabled edges",
						$time, valid_o, en_count);
				end
				if (valid_o === 1'b1) begin
					if (tail_q.size() == 0) begin
						errors++;
						$display("valid_o is high but no input has been recorded");
					end else begin
						exp_tail = tail_q.pop_front();
						exp_mid  = mid_q.pop_front();
						// Items that straddle a midstate change are undefined
						if (exp_mid != midstate_i) begin
							skipped++;
						end else begin
							expected = sha256_ref(exp_mid, exp_tail);
							checked++;
							if (digest_o !== expected) begin
								errors++;
								$display("[ERROR] %0t: item %0d digest %h, expected %h",
									$time, en_count - LATENCY, digest_o, expected);
							end
						end
					end
				end else if (digest_o !== '0) begin
					errors++;
					$display("[ERROR] %0t: digest %h is not zero while filling",
						$time, digest_o);
				end
				tail_q.push_back(tail_i);
				mid_q.push_back(midstate_i);
				en_count++;
			end
		end
		prev_en     = en_i;
		prev_valid  = valid_o;
		prev_digest = digest_o;
	end

	always @(posedge CLK) begin : watchdog
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

endmodule

// ==== all.f ====
+incdir+tb
hw/sha256_pkg.sv
hw/sha256_sched_stage.sv
hw/sha256_round_stage.sv
hw/sha256_digest_out.sv
hw/sha256_tail_pipeline.sv
tb/tb_clock.sv
tb/tb_sha256_tail_pipeline.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_sha256_tail_pipeline
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
